//--- coeff_multiplier.sv
/*
 * Two-stage pipelined 7q8 multiply of a signed sample by a DCT coefficient.
 * The product of an operand and coefficient entered in cycle t is out in t+2.
 */
module coeff_multiplier (
    input  logic                                    clock,
    input  logic [dct_fixed_pkg::sample_width-1:0]  operand,
    input  dct_fixed_pkg::coeff_sel_e               coeff_sel,
    output logic [dct_fixed_pkg::sample_width-1:0]  product
);

    localparam int full_width = dct_fixed_pkg::sample_width + dct_fixed_pkg::coeff_width + 1;

    logic signed [dct_fixed_pkg::sample_width-1:0] operand_q;
    logic [dct_fixed_pkg::coeff_width-1:0]         coeff_q;
    logic signed [full_width-1:0]                  full_q;

    always_ff @(posedge clock) begin
        operand_q <= operand;
        coeff_q   <= dct_fixed_pkg::coeff_value(coeff_sel);
        full_q    <= operand_q * $signed({1'b0, coeff_q});  // coefficient is unsigned
    end

    // back to 7q8, bits 23 down to 8
    assign product = full_q[dct_fixed_pkg::product_lsb +: dct_fixed_pkg::sample_width];

endmodule

//--- dct_control_rom.sv
/*
 * Microprogram of the 8-point loeffler DCT, one word per step.
 * Read combinationally by the sequencer and split into control fields.
 */
module dct_control_rom (
    input  logic [ucode_pkg::pc_width-1:0]        pc,
    output logic [ucode_pkg::spad_addr_width-1:0] read_addr,
    output ucode_pkg::read_src_e                  read_src,
    output logic                                  latch_op1,
    output logic                                  negate_op1,
    output logic                                  negate_op2,
    output ucode_pkg::op_src_e                    op1_src,
    output ucode_pkg::op_src_e                    op2_src,
    output dct_fixed_pkg::coeff_sel_e             coeff_sel,
    output logic [ucode_pkg::spad_addr_width-1:0] write_addr,
    output ucode_pkg::write_dest_e                write_dest,
    output logic                                  write_en,
    output ucode_pkg::write_src_e                 write_src
);

    // short names keep one step per table row
    localparam logic y = 1'b1;
    localparam logic n = 1'b0;
    localparam ucode_pkg::read_src_e   rf  = ucode_pkg::src_fetch;
    localparam ucode_pkg::read_src_e   rs  = ucode_pkg::src_spad;
    localparam ucode_pkg::op_src_e     mem = ucode_pkg::op_mem;
    localparam ucode_pkg::op_src_e     mul = ucode_pkg::op_mul;
    localparam ucode_pkg::write_dest_e ds  = ucode_pkg::dest_spad;
    localparam ucode_pkg::write_dest_e dr  = ucode_pkg::dest_result;
    localparam ucode_pkg::write_src_e  wa  = ucode_pkg::wsrc_adder;
    localparam ucode_pkg::write_src_e  wm  = ucode_pkg::wsrc_mul;
    localparam dct_fixed_pkg::coeff_sel_e c3c = dct_fixed_pkg::c3_cos;
    localparam dct_fixed_pkg::coeff_sel_e c3s = dct_fixed_pkg::c3_sin;
    localparam dct_fixed_pkg::coeff_sel_e c1c = dct_fixed_pkg::c1_cos;
    localparam dct_fixed_pkg::coeff_sel_e c1s = dct_fixed_pkg::c1_sin;
    localparam dct_fixed_pkg::coeff_sel_e r6c = dct_fixed_pkg::r2c6_cos;
    localparam dct_fixed_pkg::coeff_sel_e r6s = dct_fixed_pkg::r2c6_sin;
    localparam dct_fixed_pkg::coeff_sel_e r2  = dct_fixed_pkg::sqrt2;
    localparam dct_fixed_pkg::coeff_sel_e r24 = dct_fixed_pkg::sqrt2_over4;

    logic [21:0] word;

    always_comb begin
        case (pc)
            // raddr  src lat n1 n2 op1  op2  coeff waddr  dest wen wsrc
            // stage one forms sums and differences of mirrored inputs
            6'd0:  word = {5'd0,  rf, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd1:  word = {5'd7,  rf, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd2:  word = {5'd1,  rf, n, n, n, mem, mem, c3c, 5'd0,  ds, y, wa};  // x0 + x7
            6'd3:  word = {5'd6,  rf, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd4:  word = {5'd2,  rf, n, n, n, mem, mem, c3c, 5'd1,  ds, y, wa};  // x1 + x6
            6'd5:  word = {5'd5,  rf, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd6:  word = {5'd3,  rf, n, n, n, mem, mem, c3c, 5'd2,  ds, y, wa};  // x2 + x5
            6'd7:  word = {5'd4,  rf, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd8:  word = {5'd3,  rf, n, n, n, mem, mem, c3c, 5'd3,  ds, y, wa};  // x3 + x4
            6'd9:  word = {5'd4,  rf, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd10: word = {5'd2,  rf, n, n, y, mem, mem, c3c, 5'd4,  ds, y, wa};  // x3 - x4
            6'd11: word = {5'd5,  rf, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd12: word = {5'd1,  rf, n, n, y, mem, mem, c3c, 5'd5,  ds, y, wa};  // x2 - x5
            6'd13: word = {5'd6,  rf, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd14: word = {5'd0,  rf, n, n, y, mem, mem, c3c, 5'd6,  ds, y, wa};  // x1 - x6
            6'd15: word = {5'd7,  rf, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd16: word = {5'd0,  rs, n, n, y, mem, mem, c3c, 5'd7,  ds, y, wa};  // x0 - x7
            // stage two, even butterflies
            6'd17: word = {5'd3,  rs, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd18: word = {5'd1,  rs, n, n, n, mem, mem, c3c, 5'd8,  ds, y, wa};
            6'd19: word = {5'd2,  rs, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd20: word = {5'd1,  rs, n, n, n, mem, mem, c3c, 5'd9,  ds, y, wa};
            6'd21: word = {5'd2,  rs, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd22: word = {5'd0,  rs, n, n, y, mem, mem, c3c, 5'd10, ds, y, wa};
            6'd23: word = {5'd3,  rs, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd24: word = {5'd4,  rs, n, n, y, mem, mem, c3c, 5'd11, ds, y, wa};
            // rotations by c3 and c1, products return two steps after entry
            6'd25: word = {5'd7,  rs, n, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd26: word = {5'd4,  rs, n, n, n, mem, mem, c3s, 5'd0,  ds, n, wa};
            6'd27: word = {5'd7,  rs, y, n, n, mul, mem, c3s, 5'd0,  ds, n, wa};
            6'd28: word = {5'd5,  rs, n, n, n, mem, mul, c3c, 5'd12, ds, y, wa};
            6'd29: word = {5'd6,  rs, y, n, n, mul, mem, c1c, 5'd0,  ds, n, wa};
            6'd30: word = {5'd5,  rs, n, y, n, mem, mul, c1s, 5'd15, ds, y, wa};
            6'd31: word = {5'd6,  rs, y, n, n, mul, mem, c1s, 5'd0,  ds, n, wa};
            6'd32: word = {5'd8,  rs, n, n, n, mem, mul, c1c, 5'd13, ds, y, wa};
            6'd33: word = {5'd9,  rs, y, n, n, mul, mem, r24, 5'd0,  ds, n, wa};
            6'd34: word = {5'd8,  rs, n, y, n, mem, mul, r24, 5'd14, ds, y, wa};
            // stage three, even outputs through sqrt2/4 and r2c6
            6'd35: word = {5'd9,  rs, y, n, n, mul, mem, r24, 5'd0,  ds, n, wa};
            6'd36: word = {5'd10, rs, n, n, n, mem, mul, r24, 5'd0,  dr, y, wa};  // y0
            6'd37: word = {5'd11, rs, y, n, n, mul, mem, r6c, 5'd0,  ds, n, wa};
            6'd38: word = {5'd10, rs, n, n, y, mem, mul, r6s, 5'd4,  dr, y, wa};  // y4
            6'd39: word = {5'd11, rs, y, n, n, mul, mem, r6s, 5'd0,  ds, n, wa};
            6'd40: word = {5'd0,  rs, n, n, n, mem, mul, r6c, 5'd2,  dr, y, wa};  // y2
            6'd41: word = {5'd12, rs, y, n, n, mul, mem, c3c, 5'd0,  ds, n, wa};
            6'd42: word = {5'd14, rs, y, y, n, mem, mul, c3c, 5'd6,  dr, y, wa};  // y6
            // odd butterflies
            6'd43: word = {5'd13, rs, n, n, n, mem, mem, c3c, 5'd20, ds, y, wa};
            6'd44: word = {5'd15, rs, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd45: word = {5'd12, rs, n, y, n, mem, mem, c3c, 5'd21, ds, y, wa};
            6'd46: word = {5'd14, rs, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd47: word = {5'd13, rs, n, n, y, mem, mem, c3c, 5'd22, ds, y, wa};
            6'd48: word = {5'd15, rs, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd49: word = {5'd20, rs, n, n, n, mem, mem, c3c, 5'd23, ds, y, wa};
            6'd50: word = {5'd23, rs, y, n, n, mem, mem, c3c, 5'd0,  ds, n, wa};
            6'd51: word = {5'd23, rs, n, y, n, mem, mem, c3c, 5'd7,  dr, y, wa};  // y7
            6'd52: word = {5'd21, rs, n, n, n, mem, mem, c3c, 5'd1,  dr, y, wa};  // y1
            // y3 and y5 go straight out of the multiplier
            6'd53: word = {5'd22, rs, n, n, n, mem, mem, r2,  5'd0,  ds, n, wa};
            6'd54: word = {5'd0,  rs, n, n, n, mem, mem, r2,  5'd0,  ds, n, wa};
            6'd55: word = {5'd0,  rs, n, n, n, mem, mem, c3c, 5'd3,  dr, y, wm};
            6'd56: word = {5'd0,  rs, n, n, n, mem, mem, c3c, 5'd5,  dr, y, wm};
            default: word = '0;   // idle once the program is done
        endcase
    end

    assign read_addr  = word[21:17];
    assign read_src   = ucode_pkg::read_src_e'(word[16]);
    assign latch_op1  = word[15];
    assign negate_op1 = word[14];
    assign negate_op2 = word[13];
    assign op1_src    = ucode_pkg::op_src_e'(word[12]);
    assign op2_src    = ucode_pkg::op_src_e'(word[11]);
    assign coeff_sel  = dct_fixed_pkg::coeff_sel_e'(word[10:8]);
    assign write_addr = word[7:3];
    assign write_dest = ucode_pkg::write_dest_e'(word[2]);
    assign write_en   = word[1];
    assign write_src  = ucode_pkg::write_src_e'(word[0]);

endmodule

//--- dct_datapath.sv
/*
 * Arithmetic of the DCT. Operand latch, adder with negation on both inputs
 * and the coefficient multiplier, steered by the sequencer fields.
 */
module dct_datapath (
    input  logic                                   clock,
    input  logic                                   nreset,
    input  logic [dct_fixed_pkg::sample_width-1:0] fetch_data,
    input  logic [dct_fixed_pkg::sample_width-1:0] spad_read_data,
    input  ucode_pkg::read_src_e                   read_src,
    input  logic                                   latch_op1,
    input  logic                                   negate_op1,
    input  logic                                   negate_op2,
    input  ucode_pkg::op_src_e                     op1_src,
    input  ucode_pkg::op_src_e                     op2_src,
    input  dct_fixed_pkg::coeff_sel_e              coeff_sel,
    input  ucode_pkg::write_src_e                  write_src,
    output logic [dct_fixed_pkg::sample_width-1:0] write_data
);

    ucode_pkg::read_src_e                   read_src_q;
    logic [dct_fixed_pkg::sample_width-1:0] operand_bus;
    logic [dct_fixed_pkg::sample_width-1:0] mul_out;
    logic [dct_fixed_pkg::sample_width-1:0] op_latch;
    logic [dct_fixed_pkg::sample_width-1:0] operand_2;
    logic [dct_fixed_pkg::sample_width-1:0] lhs;
    logic [dct_fixed_pkg::sample_width-1:0] rhs;
    logic [dct_fixed_pkg::sample_width-1:0] sum;

    always_ff @(posedge clock) begin
        if (nreset) begin
            read_src_q <= ucode_pkg::src_fetch;
            op_latch   <= '0;
        end else begin
            read_src_q <= read_src;   // lines up with the memory latency
            if (latch_op1) begin
                op_latch <= (op1_src == ucode_pkg::op_mul) ? mul_out : operand_bus;
            end
        end
    end

    assign operand_bus = (read_src_q == ucode_pkg::src_spad) ? spad_read_data : fetch_data;
    assign operand_2   = (op2_src == ucode_pkg::op_mul) ? mul_out : operand_bus;

    // two's complement, the sum wraps at 16 bits
    assign lhs = negate_op1 ? -op_latch : op_latch;
    assign rhs = negate_op2 ? -operand_2 : operand_2;
    assign sum = lhs + rhs;

    assign write_data = (write_src == ucode_pkg::wsrc_mul) ? mul_out : sum;

    coeff_multiplier i_mul (
        .clock,
        .operand   (operand_bus),
        .coeff_sel,
        .product   (mul_out)
    );

endmodule

//--- dct_fixed_pkg.sv
/*
 * 7q8 number format and the coefficient set of the loeffler DCT.
 * Shared by the control ROM and the coefficient multiplier.
 */
package dct_fixed_pkg;

    localparam int sample_width = 16;   // signed 7q8 data word
    localparam int coeff_width  = 9;    // unsigned 7q8 coefficient
    localparam int product_lsb  = 8;    // drops the extra fraction bits of a product

    typedef enum logic [2:0] {
        c3_cos,
        c3_sin,
        c1_cos,
        c1_sin,
        r2c6_cos,
        r2c6_sin,
        sqrt2,
        sqrt2_over4
    } coeff_sel_e;

    function automatic logic [coeff_width-1:0] coeff_value(input coeff_sel_e sel);
        case (sel)
            c3_cos:   coeff_value = 9'd213;
            c3_sin:   coeff_value = 9'd142;
            c1_cos:   coeff_value = 9'd251;
            c1_sin:   coeff_value = 9'd50;
            r2c6_cos: coeff_value = 9'd139;
            r2c6_sin: coeff_value = 9'd334;
            sqrt2:    coeff_value = 9'd362;
            default:  coeff_value = 9'd91;  // sqrt2 / 4
        endcase
    endfunction

endpackage

//--- dct_golden.txt
# each line holds input samples x0..x7 then expected coefficients y0..y7
# all words are 16-bit signed 7q8 in hex
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0100 0000 0000 0000 0000 0000 0000 0000 005b 0163 014e 012d 005b 00c8 008b 0047
0000 0000 0000 0000 0000 0000 0000 0100 005b fe9d 014e fed2 005b ff37 008b ffb9
0000 0000 0000 0100 0000 0000 0000 0000 005b 0047 feb2 ff37 005b 012d ff75 fe9d
0000 0100 0000 0000 0000 0000 0000 0000 005b 012d 008b ffb9 ffa5 fe9d feb2 ff37
0100 0100 0100 0100 0100 0100 0100 0100 02d8 0000 0000 0000 0000 0000 0000 0000
0100 ff00 0100 ff00 0100 ff00 0100 ff00 0000 0170 0000 01b3 0000 028a 0000 0740
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff fffc 0000 0000 0000 0000 0000 0000 0000
7fff 0000 0000 0000 0000 0000 0000 0000 2d7f b17e a6fe 9697 2d7f 6464 457f 2380

//--- dct_scratchpad.sv
/*
 * Store for the intermediate DCT terms, one write port and one read port.
 * Read data appears one cycle after the address.
 */
module dct_scratchpad (
    input  logic                                   clock,
    input  logic                                   write_en,
    input  logic [ucode_pkg::spad_addr_width-1:0]  write_addr,
    input  logic [ucode_pkg::spad_addr_width-1:0]  read_addr,
    input  logic [dct_fixed_pkg::sample_width-1:0] write_data,
    output logic [dct_fixed_pkg::sample_width-1:0] read_data
);

    logic [dct_fixed_pkg::sample_width-1:0] mem [ucode_pkg::spad_depth];

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr];  // old word on a same-address write
    end

endmodule

//--- dct_sequencer.sv
/*
 * Microprogram counter of the DCT. Steps once per cycle after reset,
 * holds at the program end and presents the fields of the current step.
 */
module dct_sequencer (
    input  logic                                  clock,
    input  logic                                  nreset,
    output logic                                  finished,
    output logic [ucode_pkg::spad_addr_width-1:0] read_addr,
    output ucode_pkg::read_src_e                  read_src,
    output logic                                  latch_op1,
    output logic                                  negate_op1,
    output logic                                  negate_op2,
    output ucode_pkg::op_src_e                    op1_src,
    output ucode_pkg::op_src_e                    op2_src,
    output dct_fixed_pkg::coeff_sel_e             coeff_sel,
    output logic [ucode_pkg::spad_addr_width-1:0] write_addr,
    output ucode_pkg::write_dest_e                write_dest,
    output logic                                  write_en,
    output ucode_pkg::write_src_e                 write_src
);

    logic [ucode_pkg::pc_width-1:0] pc;

    always_ff @(posedge clock) begin
        if (nreset) begin
            pc <= '0;
        end else if (pc != ucode_pkg::ucode_len) begin
            pc <= pc + 1'b1;
        end
    end

    // high from the last write step onwards
    assign finished = (pc >= ucode_pkg::ucode_len - 1'b1);

    dct_control_rom i_rom (
        .pc,
        .read_addr, .read_src, .latch_op1, .negate_op1, .negate_op2,
        .op1_src, .op2_src, .coeff_sel,
        .write_addr, .write_dest, .write_en, .write_src
    );

endmodule

//--- list.f
dct_fixed_pkg.sv
ucode_pkg.sv
dct_control_rom.sv
dct_sequencer.sv
coeff_multiplier.sv
dct_scratchpad.sv
dct_datapath.sv
loeffler_dct_8.sv
tb_loeffler_dct_8.sv

//--- loeffler_dct_8.sv
/*
 * 8-point forward DCT, loeffler factorisation, run by a 57-step microprogram.
 * Pulse nreset high to start a transform. The eight coefficients leave
 * through result_wren, result_addr and result_data, and finished then stays high.
 */
module loeffler_dct_8 (
    input  logic                                   clock,
    input  logic                                   nreset,
    output logic [ucode_pkg::fetch_addr_width-1:0] fetch_addr,
    input  logic [dct_fixed_pkg::sample_width-1:0] fetch_data,
    output logic                                   result_wren,
    output logic [2:0]                             result_addr,
    output logic [dct_fixed_pkg::sample_width-1:0] result_data,
    output logic                                   finished
);

    logic [ucode_pkg::spad_addr_width-1:0]  read_addr;
    ucode_pkg::read_src_e                   read_src;
    logic                                   latch_op1;
    logic                                   negate_op1;
    logic                                   negate_op2;
    ucode_pkg::op_src_e                     op1_src;
    ucode_pkg::op_src_e                     op2_src;
    dct_fixed_pkg::coeff_sel_e              coeff_sel;
    logic [ucode_pkg::spad_addr_width-1:0]  write_addr;
    ucode_pkg::write_dest_e                 write_dest;
    logic                                   write_en;
    ucode_pkg::write_src_e                  write_src;
    logic [dct_fixed_pkg::sample_width-1:0] spad_read_data;
    logic [dct_fixed_pkg::sample_width-1:0] write_data;
    logic                                   spad_wren;

    // one write per step, to the scratchpad or to the result port
    assign spad_wren   = write_en && (write_dest == ucode_pkg::dest_spad);
    assign result_wren = write_en && (write_dest == ucode_pkg::dest_result);
    assign result_addr = write_addr[2:0];
    assign result_data = write_data;   // only valid while result_wren is high
    assign fetch_addr  = read_addr[ucode_pkg::fetch_addr_width-1:0];

    dct_sequencer i_sequencer (
        .clock, .nreset, .finished,
        .read_addr, .read_src, .latch_op1, .negate_op1, .negate_op2,
        .op1_src, .op2_src, .coeff_sel,
        .write_addr, .write_dest, .write_en, .write_src
    );

    dct_datapath i_datapath (
        .clock, .nreset, .fetch_data, .spad_read_data,
        .read_src, .latch_op1, .negate_op1, .negate_op2,
        .op1_src, .op2_src, .coeff_sel, .write_src,
        .write_data
    );

    dct_scratchpad i_scratchpad (
        .clock,
        .write_en   (spad_wren),
        .write_addr,
        .read_addr,
        .write_data,
        .read_data  (spad_read_data)
    );

endmodule

//--- tb_loeffler_dct_8.sv
/*
 * Testbench of the loeffler DCT. Runs every vector of dct_golden.txt through
 * the DUT, models the fetch memory and checks the result port writes.
 */
module tb_loeffler_dct_8;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_vectors  = 32;
    localparam int abort_vector = 3;    // this vector is preceded by an aborted run
    localparam int abort_cycles = 20;

    logic        clock;
    logic        nreset;
    logic [2:0]  fetch_addr;
    logic [15:0] fetch_data;
    logic        result_wren;
    logic [2:0]  result_addr;
    logic [15:0] result_data;
    logic        finished;

    logic [15:0] gold_x [max_vectors][8];
    logic [15:0] gold_y [max_vectors][8];
    logic [15:0] mem_x [8];      // vector currently held by the fetch memory
    logic [2:0]  addr_q;
    logic [15:0] captured [8];
    int          hits [8];
    int          num_vectors;
    int          write_count;
    bit          done_seen;
    bit          rst_prev;
    int          value_errors;
    int          protocol_errors;
    int          cycles;
    int          cycle_limit;

    loeffler_dct_8 i_dut (
        .clock, .nreset, .fetch_addr, .fetch_data,
        .result_wren, .result_addr, .result_data, .finished
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // fetch memory, data follows the address one cycle later
    always @(negedge clock) begin
        fetch_data <= mem_x[addr_q];
        addr_q     <= fetch_addr;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not complete within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // result port monitor, state is cleared by every reset
    always @(posedge clock) begin
        if (nreset) begin
            if (rst_prev) begin
                assert (!finished && !result_wren) else begin
                    $display("at %0t finished or result_wren was high during reset", $time);
                    protocol_errors++;
                end
            end
            write_count = 0;
            done_seen   = 1'b0;
            for (int a = 0; a < 8; a++) begin
                hits[a]     = 0;
                captured[a] = 'x;
            end
        end else begin
            if (result_wren) begin
                assert (!done_seen) else begin
                    $display("at %0t a result write came after finished", $time);
                    protocol_errors++;
                end
                hits[result_addr]++;
                captured[result_addr] = result_data;
                write_count++;
                assert (finished == (write_count == 8)) else begin
                    $display("at %0t finished did not rise with the last write", $time);
                    protocol_errors++;
                end
            end else begin
                assert (finished == done_seen) else begin
                    $display("at %0t finished changed without a result write", $time);
                    protocol_errors++;
                end
            end
            done_seen = finished;
        end
        rst_prev = nreset;
    end

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [15:0] v [16];
        fd = $fopen("dct_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open dct_golden.txt");
            protocol_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                            v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
                if (n == 16 && num_vectors < max_vectors) begin   // comment lines give 0
                    for (int k = 0; k < 8; k++) begin
                        gold_x[num_vectors][k] = v[k];
                        gold_y[num_vectors][k] = v[k + 8];
                    end
                    num_vectors++;
                end
            end
            $fclose(fd);
            if (num_vectors == 0) begin
                $display("dct_golden.txt holds no vectors");
                protocol_errors++;
            end
        end
    endtask

    task automatic apply_reset(input int n);
        @(negedge clock);
        nreset = 1'b1;
        repeat (n) @(negedge clock);
        nreset = 1'b0;
    endtask

    task automatic check_results(input int idx);
        assert (write_count == 8) else begin
            $display("vector %0d made %0d result writes instead of 8", idx, write_count);
            protocol_errors++;
        end
        for (int a = 0; a < 8; a++) begin
            assert (hits[a] == 1) else begin
                $display("vector %0d wrote result_addr %0d %0d times", idx, a, hits[a]);
                protocol_errors++;
            end
            assert (captured[a] === gold_y[idx][a]) else begin
                $display("[FAIL] %0t vector %0d y%0d got %h expected %h",
                         $time, idx, a, captured[a], gold_y[idx][a]);
                value_errors++;
            end
        end
    endtask

    task automatic run_transform(input int idx);
        for (int k = 0; k < 8; k++) begin
            mem_x[k] = gold_x[idx][k];
        end
        apply_reset(3);
        while (finished !== 1'b1) @(negedge clock);
        repeat (2) @(negedge clock);   // finished must hold with no more writes
        check_results(idx);
    endtask

    // start on another vector and cut it off before any result write
    task automatic abort_transform(input int idx);
        for (int k = 0; k < 8; k++) begin
            mem_x[k] = gold_x[(idx + 1) % num_vectors][k];
        end
        apply_reset(3);
        repeat (abort_cycles) @(negedge clock);
        assert (write_count == 0 && !finished) else begin
            $display("aborted run wrote results or finished within %0d cycles", abort_cycles);
            protocol_errors++;
        end
    endtask

    initial begin
        nreset          = 1'b1;
        fetch_data      = '0;
        addr_q          = '0;
        num_vectors     = 0;
        write_count     = 0;
        done_seen       = 1'b0;
        rst_prev        = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        cycles          = 0;
        cycle_limit     = 20;
        for (int k = 0; k < 8; k++) begin
            mem_x[k] = '0;
        end
        load_golden();
        cycle_limit = num_vectors * 80 + 20;
        for (int i = 0; i < num_vectors; i++) begin
            if (i == abort_vector) begin
                abort_transform(i);
            end
            run_transform(i);
        end
        $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- ucode_pkg.sv
/*
 * Microcode field encodings, program length and address widths
 * of the DCT sequencer.
 */
package ucode_pkg;

    localparam int pc_width         = 6;
    localparam int spad_addr_width  = 5;
    localparam int spad_depth       = 24;
    localparam int fetch_addr_width = 3;

    localparam logic [pc_width-1:0] ucode_len = 6'd57;  // pc saturates here

    // memory word that appears on the operand bus one cycle later
    typedef enum logic {src_fetch, src_spad} read_src_e;

    // source of the operand latch and of adder operand 2
    typedef enum logic {op_mem, op_mul} op_src_e;

    typedef enum logic {dest_spad, dest_result} write_dest_e;

    typedef enum logic {wsrc_adder, wsrc_mul} write_src_e;

endpackage
